//--- common/txq_macros.svh
/*
 * Transmit symbol queue constants
 * Sample widths, group sizes, symbol length and framing counts
 */
`ifndef TXQ_MACROS_SVH
`define TXQ_MACROS_SVH

// ------------------------------
// Sample and antenna layout
// ------------------------------
`define TXQ_SAMPLE_W   32
`define TXQ_LANES      4
`define TXQ_ANTS       8
`define TXQ_ANT_IDX_W  4
`define TXQ_TAG_W      8

// ------------------------------
// Symbol store and framing
// ------------------------------
`define TXQ_SYM_LEN    48
`define TXQ_ADDR_W     6
`define TXQ_RE_PER_RB  12
`define TXQ_RB_PER_SOP 4
`define TXQ_PRB_NUM    132
`define TXQ_PRB_W      9

`endif

//--- common/txq_pkg.sv
/*
 * Transmit symbol queue types
 * Word, address, tag and index vectors plus the read scheduler states
 */
`include "txq_macros.svh"

package txq_pkg;

    // One input word, antenna a at bits [a*32 +: 32]
    typedef logic [`TXQ_ANTS*`TXQ_SAMPLE_W-1:0] ant_word_t;

    // One group word, lane k holds antenna 2k+g
    typedef logic [`TXQ_LANES*`TXQ_SAMPLE_W-1:0] grp_word_t;

    // Word address inside one slot
    typedef logic [`TXQ_ADDR_W-1:0] waddr_t;

    // Antenna number, wraps at 16
    typedef logic [`TXQ_ANT_IDX_W-1:0] ant_idx_t;

    // Lane tags, group in the upper nibble and antenna in the lower
    typedef logic [`TXQ_LANES*`TXQ_TAG_W-1:0] pkg_info_t;

    // Resource block index
    typedef logic [`TXQ_PRB_W-1:0] prb_idx_t;

    // Read scheduler
    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_GRP0,
        SCHED_GRP1
    } sched_state_t;

endpackage

//--- logic/txq_ant_split.sv
/*
 * Antenna split
 * Accepts input words, splits them into even and odd antenna groups
 * and generates the write address and the symbol commit pulse
 */
module txq_ant_split (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rx_vld,
    input  txq_pkg::ant_word_t  i_rx_data,
    input  logic                i_ready,
    output logic                o_wr_en,
    output txq_pkg::waddr_t     o_wr_addr,
    output txq_pkg::grp_word_t  o_wr_even,
    output txq_pkg::grp_word_t  o_wr_odd,
    output logic                o_sym_commit
);
    `include "txq_macros.svh"
    import txq_pkg::*;

    logic   accept;
    logic   last_word;
    waddr_t word_cnt;

    assign accept    = i_rx_vld && i_ready;
    assign last_word = (word_cnt == waddr_t'(`TXQ_SYM_LEN - 1));

    // Fires with the acceptance of the final word
    assign o_sym_commit = accept && last_word;

    // Word position inside the current symbol
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            word_cnt <= '0;
        end else if (accept) begin
            if (last_word) begin
                word_cnt <= '0;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wr_en   <= 1'b0;
            o_wr_addr <= '0;
        end else begin
            o_wr_en <= accept;
            if (accept) begin
                o_wr_addr <= word_cnt;
            end
        end
    end

    // Even antennas to one group, odd antennas to the other
    always_ff @(posedge i_clk) begin
        if (accept) begin
            for (int k = 0; k < `TXQ_LANES; k++) begin
                o_wr_even[k*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W] <=
                    i_rx_data[(2*k)*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W];
                o_wr_odd[k*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W] <=
                    i_rx_data[(2*k+1)*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W];
            end
        end
    end

    a_wr_addr_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_wr_en |-> (o_wr_addr < `TXQ_SYM_LEN)
    );

endmodule

//--- logic/txq_re_framer.sv
/*
 * Resource block framer
 * Registers output words, tags each lane with its antenna and group,
 * and marks block ends, sop blocks and the PRB index
 */
module txq_re_framer (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rd_vld,
    input  logic                i_rd_grp,
    input  txq_pkg::grp_word_t  i_rd_data,
    input  txq_pkg::ant_idx_t   i_ant0_idx,
    output txq_pkg::grp_word_t  o_tx_data,
    output logic                o_tx_vld,
    output logic                o_tx_sop,
    output logic                o_tx_eop,
    output txq_pkg::prb_idx_t   o_prb_idx,
    output txq_pkg::pkg_info_t  o_pkg_info
);
    `include "txq_macros.svh"
    import txq_pkg::*;

    logic [3:0] re_cnt;
    logic [1:0] rb_cnt;

    // ------------------------------
    // Data and lane tags
    // ------------------------------
    always_ff @(posedge i_clk) begin
        ant_idx_t ant;
        o_tx_data <= i_rd_data;
        for (int k = 0; k < `TXQ_LANES; k++) begin
            ant = i_ant0_idx + ant_idx_t'(2*k) + ant_idx_t'(i_rd_grp);
            o_pkg_info[k*`TXQ_TAG_W +: `TXQ_TAG_W] <= {3'b000, i_rd_grp, ant};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_tx_vld <= 1'b0;
        end else begin
            o_tx_vld <= i_rd_vld;
        end
    end

    // ------------------------------
    // Block framing
    // ------------------------------
    // Counters hold the position of the word now on o_tx_data
    assign o_tx_eop = o_tx_vld && (re_cnt == 4'(`TXQ_RE_PER_RB - 1));
    assign o_tx_sop = o_tx_vld && (re_cnt == 4'd0) && (rb_cnt == 2'd0);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            re_cnt    <= '0;
            rb_cnt    <= '0;
            o_prb_idx <= '0;
        end else if (o_tx_vld) begin
            if (o_tx_eop) begin
                re_cnt <= '0;
                if (rb_cnt == 2'(`TXQ_RB_PER_SOP - 1)) begin
                    rb_cnt <= '0;
                end else begin
                    rb_cnt <= rb_cnt + 1'b1;
                end
                if (o_prb_idx == prb_idx_t'(`TXQ_PRB_NUM - 1)) begin
                    o_prb_idx <= '0;
                end else begin
                    o_prb_idx <= o_prb_idx + 1'b1;
                end
            end else begin
                re_cnt <= re_cnt + 1'b1;
            end
        end
    end

endmodule

//--- logic/txq_top.sv
/*
 * Transmit symbol queue
 * Antenna split, symbol store with read scheduler, and block framer
 */
module txq_top (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_rx_vld,
    input  txq_pkg::ant_word_t  i_rx_data,
    input  txq_pkg::ant_idx_t   i_ant0_idx,
    output logic                o_tready,
    output txq_pkg::grp_word_t  o_tx_data,
    output logic                o_tx_vld,
    output logic                o_tx_sop,
    output logic                o_tx_eop,
    output txq_pkg::prb_idx_t   o_prb_idx,
    output txq_pkg::pkg_info_t  o_pkg_info
);
    `include "txq_macros.svh"
    import txq_pkg::*;

    logic       wr_en;
    waddr_t     wr_addr;
    grp_word_t  wr_even;
    grp_word_t  wr_odd;
    logic       sym_commit;
    logic       sym_ready;
    logic       rd_en;
    logic       rd_grp;
    waddr_t     rd_addr;
    logic       sym_free;
    grp_word_t  rd_data;
    logic       rd_vld;
    logic       rd_data_grp;

    txq_ant_split txq_ant_split_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rx_vld     (i_rx_vld),
        .i_rx_data    (i_rx_data),
        .i_ready      (o_tready),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_even    (wr_even),
        .o_wr_odd     (wr_odd),
        .o_sym_commit (sym_commit)
    );

    txq_symbol_store txq_symbol_store_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_wr_en      (wr_en),
        .i_wr_addr    (wr_addr),
        .i_wr_even    (wr_even),
        .i_wr_odd     (wr_odd),
        .i_sym_commit (sym_commit),
        .i_rd_en      (rd_en),
        .i_rd_grp     (rd_grp),
        .i_rd_addr    (rd_addr),
        .i_sym_free   (sym_free),
        .o_ready      (o_tready),
        .o_sym_ready  (sym_ready),
        .o_rd_data    (rd_data),
        .o_rd_vld     (rd_vld),
        .o_rd_grp     (rd_data_grp)
    );

    txq_read_sched txq_read_sched_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_sym_ready  (sym_ready),
        .o_rd_en      (rd_en),
        .o_rd_grp     (rd_grp),
        .o_rd_addr    (rd_addr),
        .o_sym_free   (sym_free)
    );

    txq_re_framer txq_re_framer_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_rd_vld     (rd_vld),
        .i_rd_grp     (rd_data_grp),
        .i_rd_data    (rd_data),
        .i_ant0_idx   (i_ant0_idx),
        .o_tx_data    (o_tx_data),
        .o_tx_vld     (o_tx_vld),
        .o_tx_sop     (o_tx_sop),
        .o_tx_eop     (o_tx_eop),
        .o_prb_idx    (o_prb_idx),
        .o_pkg_info   (o_pkg_info)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the transmit symbol queue simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module txq_tb -f txq.f -o txq_sim
./obj_dir/txq_sim | tee sim.log

if grep -q "Testbench failed" sim.log || ! grep -q "Testbench passed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation PASSED"

//--- symbol_store/txq_read_sched.sv
/*
 * Read scheduler
 * Replays each stored symbol as group 0 then group 1 words,
 * back to back when the next symbol is already complete
 */
module txq_read_sched (
    input  logic             i_clk,
    input  logic             i_reset,
    input  logic             i_sym_ready,
    output logic             o_rd_en,
    output logic             o_rd_grp,
    output txq_pkg::waddr_t  o_rd_addr,
    output logic             o_sym_free
);
    `include "txq_macros.svh"
    import txq_pkg::*;

    sched_state_t state;
    logic         last_addr;

    assign last_addr  = (o_rd_addr == waddr_t'(`TXQ_SYM_LEN - 1));
    assign o_rd_en    = (state != SCHED_IDLE);
    assign o_rd_grp   = (state == SCHED_GRP1);
    assign o_sym_free = (state == SCHED_GRP1) && last_addr;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state     <= SCHED_IDLE;
            o_rd_addr <= '0;
        end else begin
            case (state)
                SCHED_IDLE: begin
                    o_rd_addr <= '0;
                    if (i_sym_ready) begin
                        state <= SCHED_GRP0;
                    end
                end
                SCHED_GRP0: begin
                    if (last_addr) begin
                        o_rd_addr <= '0;
                        state     <= SCHED_GRP1;
                    end else begin
                        o_rd_addr <= o_rd_addr + 1'b1;
                    end
                end
                SCHED_GRP1: begin
                    if (last_addr) begin
                        // Straight into the next symbol if one is waiting
                        o_rd_addr <= '0;
                        state     <= i_sym_ready ? SCHED_GRP0 : SCHED_IDLE;
                    end else begin
                        o_rd_addr <= o_rd_addr + 1'b1;
                    end
                end
                default: begin
                    state     <= SCHED_IDLE;
                    o_rd_addr <= '0;
                end
            endcase
        end
    end

    a_rd_addr_range: assert property (
        @(posedge i_clk) disable iff (i_reset)
        o_rd_en |-> (o_rd_addr < `TXQ_SYM_LEN)
    );

endmodule

//--- symbol_store/txq_symbol_store.sv
/*
 * Symbol store
 * Two-slot RAM for each antenna group with occupancy tracking,
 * input ready and complete-symbol indication
 */
module txq_symbol_store (
    input  logic                i_clk,
    input  logic                i_reset,
    input  logic                i_wr_en,
    input  txq_pkg::waddr_t     i_wr_addr,
    input  txq_pkg::grp_word_t  i_wr_even,
    input  txq_pkg::grp_word_t  i_wr_odd,
    input  logic                i_sym_commit,
    input  logic                i_rd_en,
    input  logic                i_rd_grp,
    input  txq_pkg::waddr_t     i_rd_addr,
    input  logic                i_sym_free,
    output logic                o_ready,
    output logic                o_sym_ready,
    output txq_pkg::grp_word_t  o_rd_data,
    output logic                o_rd_vld,
    output logic                o_rd_grp
);
    `include "txq_macros.svh"
    import txq_pkg::*;

    localparam int DEPTH = 2 * `TXQ_SYM_LEN;

    grp_word_t              mem_even [DEPTH];
    grp_word_t              mem_odd  [DEPTH];
    logic [`TXQ_ADDR_W:0]   wr_idx;
    logic [`TXQ_ADDR_W:0]   rd_idx;
    logic                   wr_slot;
    logic                   rd_slot;
    logic                   commit_q;
    logic [1:0]             occ;
    logic [1:0]             occ_next;

    // ------------------------------
    // Slot bookkeeping
    // ------------------------------
    always_comb begin
        occ_next = occ;
        if (i_sym_commit && !i_sym_free) begin
            occ_next = occ + 2'd1;
        end else if (!i_sym_commit && i_sym_free) begin
            occ_next = occ - 2'd1;
        end
    end

    // Counts the symbol being committed and ignores the one being freed
    assign o_sym_ready = (occ_next != 2'd0);

    // Last word is written one cycle after commit, so the slot flips late
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            occ      <= 2'd0;
            o_ready  <= 1'b1;
            commit_q <= 1'b0;
            wr_slot  <= 1'b0;
            rd_slot  <= 1'b0;
        end else begin
            occ      <= occ_next;
            o_ready  <= (occ_next < 2'd2);
            commit_q <= i_sym_commit;
            if (commit_q) begin
                wr_slot <= ~wr_slot;
            end
            if (i_sym_free) begin
                rd_slot <= ~rd_slot;
            end
        end
    end

    // ------------------------------
    // Group RAMs
    // ------------------------------
    assign wr_idx = {1'b0, i_wr_addr} + (wr_slot ? (`TXQ_ADDR_W+1)'(`TXQ_SYM_LEN) : '0);
    assign rd_idx = {1'b0, i_rd_addr} + (rd_slot ? (`TXQ_ADDR_W+1)'(`TXQ_SYM_LEN) : '0);

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem_even[wr_idx] <= i_wr_even;
            mem_odd[wr_idx]  <= i_wr_odd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rd_data <= i_rd_grp ? mem_odd[rd_idx] : mem_even[rd_idx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_rd_vld <= 1'b0;
            o_rd_grp <= 1'b0;
        end else begin
            o_rd_vld <= i_rd_en;
            o_rd_grp <= i_rd_grp;
        end
    end

    a_no_commit_full: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_sym_commit |-> (occ != 2'd2)
    );

    a_no_free_empty: assert property (
        @(posedge i_clk) disable iff (i_reset)
        i_sym_free |-> (occ != 2'd0)
    );

endmodule

//--- txq.f
+incdir+common
common/txq_pkg.sv
logic/txq_ant_split.sv
symbol_store/txq_symbol_store.sv
symbol_store/txq_read_sched.sv
logic/txq_re_framer.sv
logic/txq_top.sv
verif/txq_tb.sv

//--- verif/txq_tb.sv
/*
 * Transmit symbol queue testbench
 * Random symbols with gaps and bursts, checked word by word
 * against a reference model of the reorder and framing rules
 */
module txq_tb;
    timeunit 1ns;
    timeprecision 100ps;

    `include "txq_macros.svh"
    import txq_pkg::*;

    localparam int SYMS    = 20;
    localparam int OUT_LEN = 2 * `TXQ_SYM_LEN;
    localparam int TIMEOUT = SYMS * (`TXQ_SYM_LEN * 3 + OUT_LEN) + 500;

    logic        i_clk;
    logic        i_reset;
    logic        i_rx_vld;
    ant_word_t   i_rx_data;
    ant_idx_t    i_ant0_idx;
    logic        o_tready;
    grp_word_t   o_tx_data;
    logic        o_tx_vld;
    logic        o_tx_sop;
    logic        o_tx_eop;
    prb_idx_t    o_prb_idx;
    pkg_info_t   o_pkg_info;

    // Accepted input words, in order, and the base antenna of each symbol
    ant_word_t   acc_q[$];
    ant_idx_t    sym_ant0[SYMS];
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          out_cnt;
    int          stall_cycles;
    int          cycles;

    txq_top txq_top_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_rx_vld   (i_rx_vld),
        .i_rx_data  (i_rx_data),
        .i_ant0_idx (i_ant0_idx),
        .o_tready   (o_tready),
        .o_tx_data  (o_tx_data),
        .o_tx_vld   (o_tx_vld),
        .o_tx_sop   (o_tx_sop),
        .o_tx_eop   (o_tx_eop),
        .o_prb_idx  (o_prb_idx),
        .o_pkg_info (o_pkg_info)
    );

    always #4 i_clk = ~i_clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    task automatic rand_word(output ant_word_t w);
        logic [31:0] r;
        for (int a = 0; a < `TXQ_ANTS; a++) begin
            next_rand(r);
            w[a*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W] = r;
        end
    endtask

    // Expected output word n, counted from the first word after reset
    function automatic void txq_ref_word(
        input  int        n,
        output grp_word_t data,
        output pkg_info_t tags,
        output logic      sop,
        output logic      eop,
        output prb_idx_t  prb
    );
        int        sym;
        int        grp;
        ant_word_t word;
        ant_idx_t  ant;
        sym  = n / OUT_LEN;
        grp  = (n % OUT_LEN) / `TXQ_SYM_LEN;
        word = acc_q[sym * `TXQ_SYM_LEN + (n % `TXQ_SYM_LEN)];
        for (int k = 0; k < `TXQ_LANES; k++) begin
            data[k*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W] =
                word[(2*k+grp)*`TXQ_SAMPLE_W +: `TXQ_SAMPLE_W];
            ant = sym_ant0[sym] + ant_idx_t'(2*k + grp);
            tags[k*`TXQ_TAG_W +: `TXQ_TAG_W] = {3'b000, grp[0], ant};
        end
        eop = ((n % `TXQ_RE_PER_RB) == `TXQ_RE_PER_RB - 1);
        sop = ((n % (`TXQ_RE_PER_RB * `TXQ_RB_PER_SOP)) == 0);
        prb = prb_idx_t'((n / `TXQ_RE_PER_RB) % `TXQ_PRB_NUM);
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAILED %s: expected %0h, actual %0h", name, exp_v, act_v);
        end
    endtask

    // Holds the word until o_tready lets it through
    task automatic send_word(input ant_word_t w);
        logic taken;
        taken = 1'b0;
        i_rx_vld  <= 1'b1;
        i_rx_data <= w;
        while (!taken) begin
            @(negedge i_clk);
            taken = o_tready;
            if (!taken) begin
                stall_cycles++;
            end
            @(posedge i_clk);
        end
        acc_q.push_back(w);
    endtask

    task automatic idle_cycles(input int n);
        ant_word_t junk;
        rand_word(junk);
        i_rx_vld  <= 1'b0;
        i_rx_data <= junk;
        repeat (n) @(posedge i_clk);
    endtask

    task automatic wait_drained();
        while (out_cnt < acc_q.size() * 2) begin
            @(posedge i_clk);
        end
        repeat (2) @(posedge i_clk);
    endtask

    // ------------------------------
    // Output monitor
    // ------------------------------
    always @(negedge i_clk) begin
        grp_word_t e_data;
        pkg_info_t e_tags;
        logic      e_sop;
        logic      e_eop;
        prb_idx_t  e_prb;
        if (!i_reset && o_tx_vld) begin
            if (out_cnt >= SYMS * OUT_LEN) begin
                errors++;
                $display("Extra output word after all symbols were replayed");
            end else if (acc_q.size() < (out_cnt / OUT_LEN + 1) * `TXQ_SYM_LEN) begin
                errors++;
                $display("Output word %0d appeared before its symbol was complete", out_cnt);
            end else begin
                txq_ref_word(out_cnt, e_data, e_tags, e_sop, e_eop, e_prb);
                check_val($sformatf("word %0d data", out_cnt), e_data, o_tx_data);
                check_val($sformatf("word %0d tags", out_cnt), 128'(e_tags), 128'(o_pkg_info));
                check_val($sformatf("word %0d sop", out_cnt), 128'(e_sop), 128'(o_tx_sop));
                check_val($sformatf("word %0d eop", out_cnt), 128'(e_eop), 128'(o_tx_eop));
                check_val($sformatf("word %0d prb", out_cnt), 128'(e_prb), 128'(o_prb_idx));
            end
            out_cnt++;
        end else if (!i_reset) begin
            check_val("idle sop", '0, 128'(o_tx_sop));
            check_val("idle eop", '0, 128'(o_tx_eop));
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Testbench failed");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        ant_word_t   w;
        logic [31:0] r;
        logic        burst;
        i_clk        = 1'b0;
        i_reset      <= 1'b1;
        i_rx_vld     <= 1'b0;
        i_rx_data    <= '0;
        i_ant0_idx   <= '0;
        rng_state    = 32'hc0c580a8;
        errors       = 0;
        checks       = 0;
        out_cnt      = 0;
        stall_cycles = 0;
        cycles       = 0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;

        @(negedge i_clk);
        check_val("reset tx_vld", '0, 128'(o_tx_vld));
        check_val("reset tx_sop", '0, 128'(o_tx_sop));
        check_val("reset tx_eop", '0, 128'(o_tx_eop));
        check_val("reset tready", 128'(1'b1), 128'(o_tready));
        @(posedge i_clk);

        for (int s = 0; s < SYMS; s++) begin
            // Base antenna moves only while the queue is empty
            if (s == 6 || s == 13) begin
                idle_cycles(1);
                wait_drained();
                i_ant0_idx <= (s == 6) ? ant_idx_t'(8) : ant_idx_t'(0);
                @(posedge i_clk);
            end
            sym_ant0[s] = (s >= 6 && s < 13) ? ant_idx_t'(8) : ant_idx_t'(0);
            // Back to back words fill both slots and force back-pressure
            burst = (s >= 8 && s < 13) || (s >= 16);
            for (int i = 0; i < `TXQ_SYM_LEN; i++) begin
                rand_word(w);
                send_word(w);
                if (!burst) begin
                    next_rand(r);
                    if (r[1:0] == 2'b11) begin
                        idle_cycles(int'(r[3:2]) + 1);
                    end
                end
            end
        end
        idle_cycles(1);
        wait_drained();
        repeat (20) @(posedge i_clk);

        check_val("output words", 128'(SYMS * OUT_LEN), 128'(out_cnt));
        if (stall_cycles == 0) begin
            errors++;
            $display("o_tready never went low during the input bursts");
        end
        $display("Errors: %0d, checks: %0d, stall cycles: %0d", errors, checks, stall_cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
